//--- design/reset_consts.svh
`ifndef RESET_CONSTS_SVH
`define RESET_CONSTS_SVH

// Start-up delay after EOS, in CLK cycles
// (short value for simulation)
`define RM_STRT_DLY 64

// CLK cycles per slow tick
`define RM_TICK_DIV 8

// Slow ticks allowed for each lock wait
`define RM_POR_TMO 12

// Slow ticks allowed for ADC init done
`define RM_ADC_INIT_TMO 10

// CLK cycles the ADC reset is held, also the recovery gap before init
`define RM_ADC_RST_CYC 4

`endif

//--- design/reset_pkg.sv
`default_nettype none

package reset_pkg;

	// Power-on sequence, encoding is visible on por_state_o
	typedef enum logic [3:0] {
		DELAY     = 4'd0,
		WAIT_MMCM = 4'd1,
		WAIT_QPLL = 4'd2,
		WAIT_ADC  = 4'd3,
		ALIGN     = 4'd4,
		WAIT_BPI  = 4'd5,
		RUN       = 4'd6
	} por_state_t;

	// ADC bring-up
	typedef enum logic [2:0] {
		HOLD  = 3'd0,
		RESET = 3'd1,
		INIT  = 3'd2,
		WAIT  = 3'd3,
		READY = 3'd4
	} adc_state_t;

endpackage

`default_nettype wire

//--- design/status_if.sv
`timescale 1ns/1ns
`default_nettype none

// Synchronized board status levels, no handshake
interface status_if;

	logic mmcm_lock;
	logic qpll_lock;
	logic al_done;
	logic bpi_idle;
	// Either restart request
	logic restart;

	modport src (
		output mmcm_lock, qpll_lock, al_done, bpi_idle, restart
	);

	modport dst (
		input mmcm_lock, qpll_lock, al_done, bpi_idle, restart
	);

endinterface

`default_nettype wire

//--- design/input_sync.sv
`timescale 1ns/1ns
`default_nettype none

module input_sync (
	input  logic CLK,
	input  logic EOS,
	input  logic mmcm_lock_i,
	input  logic qpll_lock_i,
	input  logic al_done_i,
	input  logic bpi_idle_i,
	input  logic jtag_rst_i,
	input  logic csp_rst_i,
	input  logic adc_init_done_i,
	status_if.src st,
	output logic adc_init_done_o
);

	logic [6:0] async_in;
	logic [6:0] sync_r1;
	logic [6:0] sync_r2;

	assign async_in = {adc_init_done_i, csp_rst_i, jtag_rst_i, bpi_idle_i,
	                   al_done_i, qpll_lock_i, mmcm_lock_i};

	// Two flops per input, everything reads as inactive during reset
	always_ff @(posedge CLK or negedge EOS) begin
		if (!EOS) begin
			sync_r1 <= '0;
			sync_r2 <= '0;
		end else begin
			sync_r1 <= async_in;
			sync_r2 <= sync_r1;
		end
	end

	assign st.mmcm_lock = sync_r2[0];
	assign st.qpll_lock = sync_r2[1];
	assign st.al_done   = sync_r2[2];
	assign st.bpi_idle  = sync_r2[3];

	// JTAG or control-port restart
	assign st.restart = sync_r2[4] | sync_r2[5];

	assign adc_init_done_o = sync_r2[6];

endmodule

`default_nettype wire

//--- design/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "reset_consts.svh"

module tick_gen (
	input  logic CLK,
	input  logic EOS,
	output logic tick_o
);

	localparam int unsigned DIV_W = $clog2(`RM_TICK_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             wrap;

	assign wrap = (div_cnt == DIV_W'(`RM_TICK_DIV - 1));

	// Free running, one tick per wrap
	always_ff @(posedge CLK or negedge EOS) begin
		if (!EOS) begin
			div_cnt <= '0;
			tick_o  <= 1'b0;
		end else begin
			if (wrap)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			tick_o <= wrap;
		end
	end

endmodule

`default_nettype wire

//--- design/por_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "reset_consts.svh"

module por_fsm (
	input  logic                  CLK,
	input  logic                  EOS,
	input  logic                  tick_i,
	input  logic                  adc_rdy_i,
	status_if.dst                 st,
	output logic                  mmcm_rst_o,
	output logic                  adc_init_rst_o,
	output logic                  al_start_o,
	output logic                  sys_rst_o,
	output logic                  run_o,
	output reset_pkg::por_state_t por_state_o
);

	import reset_pkg::*;

	localparam int unsigned DLY_W = $clog2(`RM_STRT_DLY);
	localparam int unsigned TMO_W = $clog2(`RM_POR_TMO);

	por_state_t       state;
	por_state_t       state_nx;
	logic [DLY_W-1:0] dly_cnt;
	logic [TMO_W-1:0] tmo_cnt;
	logic             dly_done;
	logic             tmo_hit;
	logic             lock_lost;

	assign dly_done = (dly_cnt == DLY_W'(`RM_STRT_DLY - 1));
	assign tmo_hit  = tick_i && (tmo_cnt == TMO_W'(`RM_POR_TMO - 1));

	// MMCM lock must hold once it has been seen
	assign lock_lost = (state != DELAY) && (state != WAIT_MMCM) && !st.mmcm_lock;

	always_comb begin
		state_nx = state;
		case (state)
			DELAY:
				if (dly_done)
					state_nx = WAIT_MMCM;
			WAIT_MMCM:
				if (st.mmcm_lock)
					state_nx = WAIT_QPLL;
				else if (tmo_hit)
					state_nx = DELAY;
			WAIT_QPLL:
				if (st.qpll_lock)
					state_nx = WAIT_ADC;
				else if (tmo_hit)
					state_nx = DELAY;
			WAIT_ADC:
				if (adc_rdy_i)
					state_nx = ALIGN;
			ALIGN:
				if (st.al_done)
					state_nx = WAIT_BPI;
			WAIT_BPI:
				if (st.bpi_idle)
					state_nx = RUN;
			RUN:
				state_nx = RUN;
			default:
				state_nx = DELAY;
		endcase
		if (st.restart || lock_lost)
			state_nx = DELAY;
	end

	always_ff @(posedge CLK or negedge EOS) begin
		if (!EOS) begin
			state      <= DELAY;
			dly_cnt    <= '0;
			tmo_cnt    <= '0;
			al_start_o <= 1'b0;
			sys_rst_o  <= 1'b1;
			run_o      <= 1'b0;
		end else begin
			state <= state_nx;

			// A restart inside DELAY starts the delay over
			if (state_nx != state || st.restart)
				dly_cnt <= '0;
			else if (state == DELAY)
				dly_cnt <= dly_cnt + 1'b1;

			// Lock wait timeout in slow ticks
			if (state_nx != state)
				tmo_cnt <= '0;
			else if (tick_i && (state == WAIT_MMCM || state == WAIT_QPLL))
				tmo_cnt <= tmo_cnt + 1'b1;

			al_start_o <= (state_nx == ALIGN) && (state != ALIGN);
			sys_rst_o  <= (state_nx != RUN);
			run_o      <= (state_nx == RUN);
		end
	end

	assign mmcm_rst_o     = (state == DELAY);
	assign adc_init_rst_o = (state == DELAY) || (state == WAIT_MMCM) || (state == WAIT_QPLL);
	assign por_state_o    = state;

	a_al_start_single: assert property (@(posedge CLK) disable iff (!EOS)
		al_start_o |=> !al_start_o);

	a_run_out_of_reset: assert property (@(posedge CLK) disable iff (!EOS)
		run_o |-> !sys_rst_o);

endmodule

`default_nettype wire

//--- design/adc_init_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "reset_consts.svh"

module adc_init_fsm (
	input  logic CLK,
	input  logic EOS,
	input  logic tick_i,
	input  logic adc_init_rst_i,
	input  logic sys_rst_i,
	input  logic init_done_i,
	output logic adc_rst_o,
	output logic adc_init_o,
	output logic adc_rdy_o,
	output logic dsr_rst_o
);

	import reset_pkg::*;

	localparam int unsigned CNT_MAX = (`RM_ADC_INIT_TMO > `RM_ADC_RST_CYC) ?
	                                  `RM_ADC_INIT_TMO : `RM_ADC_RST_CYC;
	localparam int unsigned CNT_W   = $clog2(CNT_MAX + 1);

	adc_state_t       state;
	adc_state_t       state_nx;
	logic [CNT_W-1:0] cnt;
	logic             cyc_done;
	logic             tmo_hit;

	assign cyc_done = (cnt == CNT_W'(`RM_ADC_RST_CYC - 1));
	assign tmo_hit  = tick_i && (cnt == CNT_W'(`RM_ADC_INIT_TMO - 1));

	always_comb begin
		state_nx = state;
		case (state)
			HOLD:
				state_nx = RESET;
			RESET:
				if (cyc_done)
					state_nx = INIT;
			// Recovery gap after reset, init strobe on the way out
			INIT:
				if (cyc_done)
					state_nx = WAIT;
			WAIT:
				if (init_done_i)
					state_nx = READY;
				else if (tmo_hit)
					state_nx = RESET;
			READY:
				state_nx = READY;
			default:
				state_nx = HOLD;
		endcase
		if (adc_init_rst_i)
			state_nx = HOLD;
	end

	always_ff @(posedge CLK or negedge EOS) begin
		if (!EOS) begin
			state      <= HOLD;
			cnt        <= '0;
			adc_rst_o  <= 1'b1;
			adc_init_o <= 1'b0;
			adc_rdy_o  <= 1'b0;
			dsr_rst_o  <= 1'b1;
		end else begin
			state <= state_nx;

			// Cycles in RESET and INIT, slow ticks in WAIT
			if (state_nx != state)
				cnt <= '0;
			else if (state == RESET || state == INIT || (state == WAIT && tick_i))
				cnt <= cnt + 1'b1;

			adc_rst_o  <= (state_nx == HOLD) || (state_nx == RESET);
			adc_init_o <= (state == INIT) && (state_nx == WAIT);
			adc_rdy_o  <= (state_nx == READY);
			dsr_rst_o  <= !adc_rdy_o || sys_rst_i;
		end
	end

	a_init_single: assert property (@(posedge CLK) disable iff (!EOS)
		adc_init_o |=> !adc_init_o);

	a_rdy_out_of_reset: assert property (@(posedge CLK) disable iff (!EOS)
		adc_rdy_o |-> !adc_rst_o);

endmodule

`default_nettype wire

//--- design/reset_manager.sv
`timescale 1ns/1ns
`default_nettype none

module reset_manager (
	input  logic                  CLK,
	input  logic                  EOS,
	input  logic                  mmcm_lock_i,
	input  logic                  qpll_lock_i,
	input  logic                  al_done_i,
	input  logic                  bpi_idle_i,
	input  logic                  jtag_rst_i,
	input  logic                  csp_rst_i,
	input  logic                  adc_init_done_i,
	output logic                  mmcm_rst_o,
	output logic                  sys_rst_o,
	output logic                  run_o,
	output logic                  al_start_o,
	output logic                  adc_init_rst_o,
	output logic                  adc_rst_o,
	output logic                  adc_init_o,
	output logic                  adc_rdy_o,
	output logic                  dsr_rst_o,
	output reset_pkg::por_state_t por_state_o
);

	logic tick;
	logic adc_init_done_s;

	status_if st_if ();

	input_sync input_sync_inst (
		.CLK             (CLK),
		.EOS             (EOS),
		.mmcm_lock_i     (mmcm_lock_i),
		.qpll_lock_i     (qpll_lock_i),
		.al_done_i       (al_done_i),
		.bpi_idle_i      (bpi_idle_i),
		.jtag_rst_i      (jtag_rst_i),
		.csp_rst_i       (csp_rst_i),
		.adc_init_done_i (adc_init_done_i),
		.st              (st_if.src),
		.adc_init_done_o (adc_init_done_s)
	);

	tick_gen tick_gen_inst (
		.CLK    (CLK),
		.EOS    (EOS),
		.tick_o (tick)
	);

	por_fsm por_fsm_inst (
		.CLK            (CLK),
		.EOS            (EOS),
		.tick_i         (tick),
		.adc_rdy_i      (adc_rdy_o),
		.st             (st_if.dst),
		.mmcm_rst_o     (mmcm_rst_o),
		.adc_init_rst_o (adc_init_rst_o),
		.al_start_o     (al_start_o),
		.sys_rst_o      (sys_rst_o),
		.run_o          (run_o),
		.por_state_o    (por_state_o)
	);

	adc_init_fsm adc_init_fsm_inst (
		.CLK            (CLK),
		.EOS            (EOS),
		.tick_i         (tick),
		.adc_init_rst_i (adc_init_rst_o),
		.sys_rst_i      (sys_rst_o),
		.init_done_i    (adc_init_done_s),
		.adc_rst_o      (adc_rst_o),
		.adc_init_o     (adc_init_o),
		.adc_rdy_o      (adc_rdy_o),
		.dsr_rst_o      (dsr_rst_o)
	);

endmodule

`default_nettype wire

//--- testbench/reset_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "reset_consts.svh"

module reset_checker (
	input logic                  CLK,
	input logic                  EOS,
	input logic                  al_done_i,
	input logic                  bpi_idle_i,
	input logic                  mmcm_rst_o,
	input logic                  sys_rst_o,
	input logic                  run_o,
	input logic                  al_start_o,
	input logic                  adc_init_rst_o,
	input logic                  adc_rst_o,
	input logic                  adc_init_o,
	input logic                  adc_rdy_o,
	input logic                  dsr_rst_o,
	input reset_pkg::por_state_t por_state_o
);

	import reset_pkg::*;

	string      test_name = "reset_levels";
	int         errors = 0;
	por_state_t prev_state;
	logic       prev_rdy, prev_sys_rst, prev_init, prev_run;
	bit         first_delay, al_done_seen;
	int         dly_cycles, wait_cycles, al_pulses, rst_low_cycles;

	task automatic mismatch(input string what, input int exp, input int act);
		errors++;
		$display("CHECK FAILED test=%s %s expected=0x%0h actual=0x%0h",
		         test_name, what, exp, act);
	endtask

	// Sample on the falling edge, away from stimulus and register updates
	always @(negedge CLK) begin
		if (!EOS) begin
			if ({sys_rst_o, mmcm_rst_o, adc_init_rst_o, adc_rst_o, dsr_rst_o,
			     run_o, al_start_o, adc_init_o, adc_rdy_o} != 9'h1F0)
				mismatch("reset levels", 32'h1F0, int'({sys_rst_o, mmcm_rst_o,
				         adc_init_rst_o, adc_rst_o, dsr_rst_o, run_o, al_start_o,
				         adc_init_o, adc_rdy_o}));
			prev_state = DELAY;
			{prev_rdy, prev_sys_rst, prev_init, prev_run} = 4'b0100;
			first_delay = 1;
			{dly_cycles, wait_cycles, al_pulses, rst_low_cycles} = '0;
			al_done_seen = 0;
		end else begin
			if (first_delay && mmcm_rst_o)
				dly_cycles++;
			else if (first_delay) begin
				if (dly_cycles != `RM_STRT_DLY)
					mismatch("start-up delay cycles", `RM_STRT_DLY, dly_cycles);
				first_delay = 0;
			end

			if (por_state_o != prev_state) begin
				if (por_state_o != DELAY && int'(por_state_o) != int'(prev_state) + 1)
					mismatch("state order", int'(prev_state) + 1, int'(por_state_o));
				if (por_state_o == DELAY && (prev_state == WAIT_MMCM ||
				    prev_state == WAIT_QPLL) &&
				    wait_cycles < (`RM_POR_TMO - 1) * `RM_TICK_DIV)
					mismatch("lock timeout too early", (`RM_POR_TMO - 1) * `RM_TICK_DIV,
					         wait_cycles);
				wait_cycles = 0;
			end else begin
				if (wait_cycles > (`RM_POR_TMO + 1) * `RM_TICK_DIV &&
				    (por_state_o == WAIT_MMCM || por_state_o == WAIT_QPLL))
					mismatch("lock wait beyond timeout", (`RM_POR_TMO + 1) * `RM_TICK_DIV,
					         wait_cycles);
				wait_cycles++;
			end

			if (mmcm_rst_o != (por_state_o == DELAY))
				mismatch("mmcm_rst_o", int'(por_state_o == DELAY), int'(mmcm_rst_o));
			if (run_o != (por_state_o == RUN))
				mismatch("run_o", int'(por_state_o == RUN), int'(run_o));
			if (sys_rst_o != !run_o)
				mismatch("sys_rst_o", int'(!run_o), int'(sys_rst_o));
			if (adc_init_rst_o != (por_state_o <= WAIT_QPLL))
				mismatch("adc_init_rst_o", int'(por_state_o <= WAIT_QPLL),
				         int'(adc_init_rst_o));
			if (dsr_rst_o != (!prev_rdy || prev_sys_rst))
				mismatch("dsr_rst_o", int'(!prev_rdy || prev_sys_rst), int'(dsr_rst_o));
			if (adc_rdy_o && adc_rst_o)
				mismatch("adc_rst_o while ready", 0, 1);

			// One alignment strobe per sequence, on entry to ALIGN
			if (por_state_o == DELAY) begin
				al_pulses = 0;
				al_done_seen = 0;
			end
			if (al_start_o) begin
				al_pulses++;
				if (por_state_o != ALIGN || prev_state == ALIGN)
					mismatch("al_start_o outside ALIGN entry", int'(ALIGN),
					         int'(por_state_o));
			end
			if (al_done_i && por_state_o >= ALIGN)
				al_done_seen = 1;
			if (run_o && !prev_run) begin
				if (al_pulses != 1)
					mismatch("al_start_o pulses before RUN", 1, al_pulses);
				if (!al_done_seen || !bpi_idle_i)
					mismatch("al_done and bpi_idle before RUN", 3,
					         int'({al_done_seen, bpi_idle_i}));
			end

			if (adc_init_o && prev_init)
				mismatch("adc_init_o width", 1, 2);
			if (adc_init_o && rst_low_cycles != `RM_ADC_RST_CYC)
				mismatch($sformatf("adc_init_o delay (adc state %0d)",
				         tb_reset_manager.reset_manager_inst.adc_init_fsm_inst.state),
				         `RM_ADC_RST_CYC, rst_low_cycles);
			rst_low_cycles = adc_rst_o ? 0 : rst_low_cycles + 1;

			prev_state = por_state_o;
			prev_rdy = adc_rdy_o;
			prev_sys_rst = sys_rst_o;
			prev_init = adc_init_o;
			prev_run = run_o;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_reset_manager.sv
`timescale 1ns/1ns
`default_nettype none

`include "reset_consts.svh"

module tb_reset_manager;

	import reset_pkg::*;

	localparam int RUN_CYCLES = `RM_STRT_DLY + 2 * (`RM_POR_TMO + 1) * `RM_TICK_DIV +
	                            2 * ((`RM_ADC_INIT_TMO + 1) * `RM_TICK_DIV +
	                            2 * `RM_ADC_RST_CYC) + 150;
	localparam int NUM_RUNS = 8;
	localparam int WATCHDOG_NS = (NUM_RUNS + 2) * RUN_CYCLES * 8;

	logic CLK, EOS;
	logic mmcm_lock_i = 0, qpll_lock_i = 0, al_done_i = 0, bpi_idle_i = 0;
	logic jtag_rst_i, csp_rst_i;
	logic adc_init_done_i = 0;
	logic mmcm_rst_o, sys_rst_o, run_o, al_start_o, adc_init_rst_o;
	logic adc_rst_o, adc_init_o, adc_rdy_o, dsr_rst_o;
	por_state_t por_state_o;

	logic [31:0] model_seed = 32'd97;
	logic [31:0] stim_seed = 32'd97;
	bit    hold_mmcm = 0, hold_adc = 0;
	int    mmcm_wait, qpll_wait, adc_wait = -1, al_wait = -1;
	int    tb_errors = 0, tests_run = 0, tests_failed = 0, errs_before;
	string cur_test;

	reset_manager reset_manager_inst (.*);

	reset_checker checker_inst (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	initial begin
		CLK = 0;
		forever #4 CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	// Board model, answers the DUT 1 ns after each rising edge
	always @(posedge CLK) begin
		#1;
		if (mmcm_rst_o) begin
			mmcm_lock_i = 0;
			qpll_lock_i = 0;
			model_seed = xorshift32(model_seed);
			mmcm_wait = 5 + int'(model_seed % 36);
			model_seed = xorshift32(model_seed);
			qpll_wait = 5 + int'(model_seed % 36);
		end else begin
			if (mmcm_wait > 0)
				mmcm_wait--;
			else if (!hold_mmcm)
				mmcm_lock_i = 1;
			if (qpll_wait > 0)
				qpll_wait--;
			else
				qpll_lock_i = 1;
		end
		model_seed = xorshift32(model_seed);
		if (adc_rst_o) begin
			adc_init_done_i = 0;
			adc_wait = -1;
		end else if (adc_init_o)
			adc_wait = 3 + int'(model_seed % 20);
		else if (adc_wait > 0)
			adc_wait--;
		else if (adc_wait == 0) begin
			// A withheld answer is dropped
			if (!hold_adc)
				adc_init_done_i = 1;
			adc_wait = -1;
		end
		if (por_state_o == DELAY) begin
			{al_done_i, bpi_idle_i} = 2'b00;
			al_wait = -1;
		end else begin
			if (al_start_o)
				al_wait = 2 + int'(model_seed[15:8] % 20);
			else if (al_wait > 0)
				al_wait--;
			else if (al_wait == 0)
				al_done_i = 1;
			// Flash goes idle some time after alignment
			if (al_done_i && model_seed[26:24] == 3'd0)
				bpi_idle_i = 1;
		end
	end

	task automatic wait_state(input por_state_t target, input int limit);
		int n;
		n = 0;
		while (por_state_o != target && n < limit) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (por_state_o != target) begin
			tb_errors++;
			$display("Test %s timed out waiting for state %s", cur_test, target.name());
		end
	endtask

	task automatic pulse_restart(input bit use_jtag);
		@(posedge CLK);
		#1;
		jtag_rst_i = use_jtag;
		csp_rst_i = !use_jtag;
		repeat (2) @(posedge CLK);
		#1;
		{jtag_rst_i, csp_rst_i} = 2'b00;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		checker_inst.test_name = name;
		errs_before = tb_errors + checker_inst.errors;
	endtask

	task automatic end_test();
		int errs;
		errs = tb_errors + checker_inst.errors - errs_before;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("test %-14s %s (%0d errors)", cur_test, errs ? "failed" : "ok", errs);
	endtask

	initial begin
		int gap, t_first, pulses;
		{jtag_rst_i, csp_rst_i} = 2'b00;
		EOS = 1;
		#1 EOS = 0;
		start_test("reset_levels");
		repeat (4) @(posedge CLK);
		#1 EOS = 1;
		wait_state(WAIT_MMCM, RUN_CYCLES);
		end_test();

		start_test("bring_up");
		wait_state(RUN, RUN_CYCLES);
		end_test();

		start_test("mmcm_timeout");
		hold_mmcm = 1;
		pulse_restart(1);
		wait_state(WAIT_MMCM, RUN_CYCLES);
		wait_state(DELAY, (`RM_POR_TMO + 2) * `RM_TICK_DIV);
		hold_mmcm = 0;
		wait_state(RUN, RUN_CYCLES);
		end_test();

		start_test("adc_timeout");
		hold_adc = 1;
		pulse_restart(0);
		{pulses, gap, t_first} = '0;
		while (pulses < 2 && gap < 2 * RUN_CYCLES) begin
			@(posedge CLK);
			#1;
			gap++;
			if (adc_init_o) begin
				if (pulses == 0)
					t_first = gap;
				pulses++;
			end
		end
		gap -= t_first;
		hold_adc = 0;
		if (pulses < 2) begin
			tb_errors++;
			$display("Test adc_timeout saw no second adc_init_o strobe");
		end else if (gap < (`RM_ADC_INIT_TMO - 1) * `RM_TICK_DIV + 2 * `RM_ADC_RST_CYC ||
		             gap > (`RM_ADC_INIT_TMO + 1) * `RM_TICK_DIV + 2 * `RM_ADC_RST_CYC) begin
			tb_errors++;
			$display("CHECK FAILED test=adc_timeout init strobe gap expected=%0d..%0d actual=%0d",
			         (`RM_ADC_INIT_TMO - 1) * `RM_TICK_DIV + 2 * `RM_ADC_RST_CYC,
			         (`RM_ADC_INIT_TMO + 1) * `RM_TICK_DIV + 2 * `RM_ADC_RST_CYC, gap);
		end
		wait_state(RUN, RUN_CYCLES);
		end_test();

		start_test("random_restart");
		repeat (3) begin
			stim_seed = xorshift32(stim_seed);
			repeat (10 + int'(stim_seed % 40)) @(posedge CLK);
			pulse_restart(stim_seed[20]);
			wait_state(DELAY, 6);
			wait_state(RUN, RUN_CYCLES);
		end
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d check errors",
		         tests_run, tests_failed, tb_errors + checker_inst.errors);
		if (tests_failed == 0 && tb_errors + checker_inst.errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/reset_pkg.sv
design/status_if.sv
design/input_sync.sv
design/tick_gen.sv
design/por_fsm.sv
design/adc_init_fsm.sv
design/reset_manager.sv
testbench/reset_checker.sv
testbench/tb_reset_manager.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_reset_manager
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
